// File: source/cam_bus_pkg.sv
`default_nettype none

package cam_bus_pkg;

    // ------------------------------------------------------------
    // command word and bus byte widths
    localparam int BYTE_W     = 8;
    localparam int CMD_W      = 32;
    localparam int REG_ADDR_W = 16;  // also the data field width

    // sensor device address bytes
    localparam logic [BYTE_W-1:0] DEV_WR_ADDR = 8'h20;
    localparam logic [BYTE_W-1:0] DEV_RD_ADDR = 8'h21;

    // ------------------------------------------------------------
    // frame lengths in bytes, header included
    localparam int WR_FRAME_LEN   = 5;  // dev, reg hi, reg lo, data hi, data lo
    localparam int ADDR_FRAME_LEN = 3;  // dev, reg hi, reg lo
    localparam int RD_FRAME_LEN   = 1;  // dev only
    localparam int READ_BYTES     = 2;  // returned after a read frame

    typedef enum logic [1:0] {
        FRAME_WRITE,
        FRAME_ADDR,
        FRAME_READ
    } frame_kind_t;

endpackage

`default_nettype wire

// File: source/cam_report_pkg.sv
`default_nettype none

package cam_report_pkg;

    // ------------------------------------------------------------
    // report channel shape
    localparam int RPT_W     = 32;
    localparam int RPT_WORDS = 5;  // four text words plus the tail word

    // text part of the message, first character in the top byte
    localparam int MSG_W = (RPT_WORDS - 1) * RPT_W;

    localparam logic [MSG_W-1:0] MSG_OK  = "camera config ok";
    localparam logic [MSG_W-1:0] MSG_ERR = "camera cfg error";

    // last word of every report
    localparam logic [RPT_W-1:0] MSG_TAIL = "\n\t\t\t";

endpackage

`default_nettype wire

// File: source/cfg_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module cfg_sequencer #(
    parameter int NUM_CMDS = 4
) (
    input  wire                                   i_sys_clk,
    input  wire                                   i_sys_resetn,
    input  wire [NUM_CMDS*cam_bus_pkg::CMD_W-1:0] i_cmd_array,
    input  wire                                   i_cmd_update,
    output logic                                  o_frame_start,
    output cam_bus_pkg::frame_kind_t              o_frame_kind,
    output logic [cam_bus_pkg::CMD_W-1:0]         o_cmd_word,
    input  wire                                   i_frame_done,
    output logic                                  o_cmd_begin,
    input  wire                                   i_mismatch,
    output logic                                  o_report_start,
    output logic                                  o_report_fail
);

    localparam int IDX_W = (NUM_CMDS > 1) ? $clog2(NUM_CMDS) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_CMDS - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_WRITE,
        S_ADDR,
        S_READ,
        S_CHECK,
        S_OVER
    } state_t;

    state_t           state;
    logic [IDX_W-1:0] cmd_idx;
    logic             fail_q;  // sticky over the whole block

    // ------------------------------------------------------------
    // per-command frame sequence
    always_ff @(posedge i_sys_clk)
    begin
        if (!i_sys_resetn)
        begin
            state         <= S_IDLE;
            cmd_idx       <= '0;
            fail_q        <= 1'b0;
            o_frame_start <= 1'b0;
            o_cmd_begin   <= 1'b0;
        end
        else
        begin
            o_frame_start <= 1'b0;
            o_cmd_begin   <= 1'b0;
            case (state)
                S_IDLE:
                    if (i_cmd_update)  // strobe only counts here
                    begin
                        state         <= S_START;
                        cmd_idx       <= '0;
                        fail_q        <= 1'b0;
                        o_frame_start <= 1'b1;
                        o_cmd_begin   <= 1'b1;
                    end
                S_START: state <= S_WRITE;  // write frame already kicked off
                S_WRITE:
                    if (i_frame_done)
                    begin
                        state         <= S_ADDR;
                        o_frame_start <= 1'b1;
                    end
                S_ADDR:
                    if (i_frame_done)
                    begin
                        state         <= S_READ;
                        o_frame_start <= 1'b1;
                    end
                S_READ: if (i_frame_done) state <= S_CHECK;
                S_CHECK:
                begin
                    fail_q <= fail_q | i_mismatch;
                    if (cmd_idx == LAST_IDX)
                        state <= S_OVER;
                    else
                    begin
                        // next word, its write frame starts right away
                        cmd_idx       <= cmd_idx + 1'b1;
                        state         <= S_START;
                        o_frame_start <= 1'b1;
                        o_cmd_begin   <= 1'b1;
                    end
                end
                S_OVER:  state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_comb
    begin
        case (state)
            S_ADDR:          o_frame_kind = cam_bus_pkg::FRAME_ADDR;
            S_READ, S_CHECK: o_frame_kind = cam_bus_pkg::FRAME_READ;
            default:         o_frame_kind = cam_bus_pkg::FRAME_WRITE;
        endcase
    end

    assign o_cmd_word     = i_cmd_array[cmd_idx*cam_bus_pkg::CMD_W +: cam_bus_pkg::CMD_W];
    assign o_report_start = (state == S_OVER);
    assign o_report_fail  = fail_q;  // already holds the last check

endmodule

`default_nettype wire

// File: source/bus_frame_tx.sv
`timescale 1ns/100ps
`default_nettype none

module bus_frame_tx (
    input  wire                                i_sys_clk,
    input  wire                                i_sys_resetn,
    input  wire                                i_frame_start,
    input  cam_bus_pkg::frame_kind_t           i_frame_kind,
    input  wire [cam_bus_pkg::CMD_W-1:0]       i_cmd_word,
    output logic                               o_cfg_valid,
    output logic                               o_cfg_msync,
    output logic [cam_bus_pkg::BYTE_W-1:0]     o_cfg_mdata,
    input  wire                                i_cfg_ready,
    output logic                               o_frame_done
);

    cam_bus_pkg::frame_kind_t          kind_q;
    logic [2:0]                        byte_cnt;
    logic [2:0]                        frame_len;
    logic [cam_bus_pkg::BYTE_W-1:0]    next_byte;
    logic                              load_byte;
    logic                              wait_rdy;  // burst sent, slave still busy

    always_comb
    begin
        case (kind_q)
            cam_bus_pkg::FRAME_WRITE: frame_len = 3'(cam_bus_pkg::WR_FRAME_LEN);
            cam_bus_pkg::FRAME_ADDR:  frame_len = 3'(cam_bus_pkg::ADDR_FRAME_LEN);
            default:                  frame_len = 3'(cam_bus_pkg::RD_FRAME_LEN);
        endcase
    end

    // byte order: device, reg hi, reg lo, data hi, data lo
    always_comb
    begin
        case (byte_cnt)
            3'd0:
                next_byte = (kind_q == cam_bus_pkg::FRAME_READ) ? cam_bus_pkg::DEV_RD_ADDR
                                                                : cam_bus_pkg::DEV_WR_ADDR;
            3'd1:    next_byte = i_cmd_word[31:24];
            3'd2:    next_byte = i_cmd_word[23:16];
            3'd3:    next_byte = i_cmd_word[15:8];
            default: next_byte = i_cmd_word[7:0];
        endcase
    end

    assign load_byte = o_cfg_valid || (o_cfg_msync && byte_cnt != frame_len);

    // ------------------------------------------------------------
    // valid pulse, burst, then wait for ready
    always_ff @(posedge i_sys_clk)
    begin
        if (!i_sys_resetn)
        begin
            kind_q       <= cam_bus_pkg::FRAME_WRITE;
            o_cfg_valid  <= 1'b0;
            o_cfg_msync  <= 1'b0;
            byte_cnt     <= '0;
            wait_rdy     <= 1'b0;
            o_frame_done <= 1'b0;
        end
        else
        begin
            o_cfg_valid  <= i_frame_start;
            o_frame_done <= 1'b0;
            if (i_frame_start)
            begin
                kind_q   <= i_frame_kind;
                byte_cnt <= '0;
            end
            else if (load_byte)
                byte_cnt <= byte_cnt + 1'b1;

            if (o_cfg_valid)
                o_cfg_msync <= 1'b1;
            else if (o_cfg_msync && byte_cnt == frame_len)
            begin
                o_cfg_msync <= 1'b0;  // last byte is on the bus now
                wait_rdy    <= 1'b1;
            end
            else if (wait_rdy && i_cfg_ready)
            begin
                wait_rdy     <= 1'b0;
                o_frame_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_sys_clk)
    begin
        if (load_byte)
            o_cfg_mdata <= next_byte;
    end

endmodule

`default_nettype wire

// File: source/readback_check.sv
`timescale 1ns/100ps
`default_nettype none

module readback_check #(
    parameter logic [cam_bus_pkg::REG_ADDR_W-1:0] CHECK_REG = 16'h3012
) (
    input  wire                               i_sys_clk,
    input  wire                               i_sys_resetn,
    input  wire                               i_clear,
    input  wire [cam_bus_pkg::CMD_W-1:0]      i_cmd_word,
    input  wire                               i_cfg_ssync,
    input  wire [cam_bus_pkg::BYTE_W-1:0]     i_cfg_sdata,
    input  wire                               i_read_done,
    output logic                              o_mismatch
);

    localparam int VAL_W = cam_bus_pkg::READ_BYTES * cam_bus_pkg::BYTE_W;
    localparam int RW    = cam_bus_pkg::REG_ADDR_W;

    logic [1:0]       byte_idx;
    logic [VAL_W-1:0] rd_value;
    logic             take_byte;
    logic             reg_hit;

    assign take_byte = i_cfg_ssync && (byte_idx < cam_bus_pkg::READ_BYTES);
    assign reg_hit   = (i_cmd_word[cam_bus_pkg::CMD_W-1 -: RW] == CHECK_REG);

    always_ff @(posedge i_sys_clk)
    begin
        if (!i_sys_resetn || i_clear)  // fresh state per command
        begin
            byte_idx   <= '0;
            o_mismatch <= 1'b0;
        end
        else
        begin
            if (take_byte)
                byte_idx <= byte_idx + 1'b1;
            if (i_read_done && reg_hit && rd_value != i_cmd_word[RW-1:0])
                o_mismatch <= 1'b1;
        end
    end

    // high byte arrives first
    always_ff @(posedge i_sys_clk)
    begin
        if (take_byte)
            rd_value[(cam_bus_pkg::READ_BYTES-1-byte_idx)*cam_bus_pkg::BYTE_W +:
                     cam_bus_pkg::BYTE_W] <= i_cfg_sdata;
    end

endmodule

`default_nettype wire

// File: source/status_reporter.sv
`timescale 1ns/100ps
`default_nettype none

module status_reporter (
    input  wire                                 i_sys_clk,
    input  wire                                 i_sys_resetn,
    input  wire                                 i_report_start,
    input  wire                                 i_report_fail,
    output logic                                o_rpt_valid,
    input  wire                                 i_rpt_ready,
    input  wire                                 i_rpt_ssync,
    output logic                                o_rpt_msync,
    output logic [cam_report_pkg::RPT_W-1:0]    o_rpt_mdata
);

    localparam int CNT_W = $clog2(cam_report_pkg::RPT_WORDS + 1);
    localparam int NW    = cam_report_pkg::RPT_WORDS;
    localparam int W     = cam_report_pkg::RPT_W;

    logic                             fail_q;
    logic                             wait_sync;  // handshake done, no burst yet
    logic [CNT_W-1:0]                 word_cnt;
    logic                             load_word;
    logic [cam_report_pkg::MSG_W-1:0] msg;
    logic [W-1:0]                     next_word;

    assign msg = fail_q ? cam_report_pkg::MSG_ERR : cam_report_pkg::MSG_OK;

    always_comb
    begin
        if (word_cnt < CNT_W'(NW - 1))
            next_word = msg[(NW - 2 - word_cnt)*W +: W];
        else
            next_word = cam_report_pkg::MSG_TAIL;
    end

    assign load_word = (wait_sync && i_rpt_ssync) || (o_rpt_msync && word_cnt != CNT_W'(NW));

    // ------------------------------------------------------------
    // valid until ready, then ssync, then the word burst
    always_ff @(posedge i_sys_clk)
    begin
        if (!i_sys_resetn)
        begin
            fail_q      <= 1'b0;
            o_rpt_valid <= 1'b0;
            wait_sync   <= 1'b0;
            o_rpt_msync <= 1'b0;
            word_cnt    <= '0;
        end
        else
        begin
            if (i_report_start)
            begin
                fail_q      <= i_report_fail;  // verdict for this report
                o_rpt_valid <= 1'b1;
                word_cnt    <= '0;
            end
            else if (o_rpt_valid && i_rpt_ready)
            begin
                o_rpt_valid <= 1'b0;
                wait_sync   <= 1'b1;
            end
            else if (load_word)
                word_cnt <= word_cnt + 1'b1;

            if (wait_sync && i_rpt_ssync)
            begin
                wait_sync   <= 1'b0;
                o_rpt_msync <= 1'b1;
            end
            else if (o_rpt_msync && word_cnt == CNT_W'(NW))
                o_rpt_msync <= 1'b0;  // tail word was the last
        end
    end

    always_ff @(posedge i_sys_clk)
    begin
        if (load_word)
            o_rpt_mdata <= next_word;
    end

endmodule

`default_nettype wire

// File: source/cam_cfg_top.sv
`timescale 1ns/100ps
`default_nettype none

module cam_cfg_top #(
    parameter int                                 NUM_CMDS  = 4,
    parameter logic [cam_bus_pkg::REG_ADDR_W-1:0] CHECK_REG = 16'h3012
) (
    input  wire                                   i_sys_clk,
    input  wire                                   i_sys_resetn,
    // command block
    input  wire [NUM_CMDS*cam_bus_pkg::CMD_W-1:0] i_cmd_array,
    input  wire                                   i_cmd_update,
    // command channel to the sensor
    output wire                                   o_cfg_valid,
    output wire                                   o_cfg_msync,
    output wire [cam_bus_pkg::BYTE_W-1:0]         o_cfg_mdata,
    input  wire                                   i_cfg_ready,
    input  wire                                   i_cfg_ssync,
    input  wire [cam_bus_pkg::BYTE_W-1:0]         i_cfg_sdata,
    // report channel
    output wire                                   o_rpt_valid,
    output wire                                   o_rpt_msync,
    output wire [cam_report_pkg::RPT_W-1:0]       o_rpt_mdata,
    input  wire                                   i_rpt_ready,
    input  wire                                   i_rpt_ssync
);

    wire                              frame_start;
    cam_bus_pkg::frame_kind_t         frame_kind;
    wire [cam_bus_pkg::CMD_W-1:0]     cmd_word;
    wire                              frame_done;
    wire                              cmd_begin;
    wire                              mismatch;
    wire                              read_done;
    wire                              report_start;
    wire                              report_fail;

    // only a read frame ends with captured bytes
    assign read_done = frame_done && (frame_kind == cam_bus_pkg::FRAME_READ);

    cfg_sequencer #(
        .NUM_CMDS (NUM_CMDS)
    ) u_sequencer (
        .i_sys_clk      (i_sys_clk),
        .i_sys_resetn   (i_sys_resetn),
        .i_cmd_array    (i_cmd_array),
        .i_cmd_update   (i_cmd_update),
        .o_frame_start  (frame_start),
        .o_frame_kind   (frame_kind),
        .o_cmd_word     (cmd_word),
        .i_frame_done   (frame_done),
        .o_cmd_begin    (cmd_begin),
        .i_mismatch     (mismatch),
        .o_report_start (report_start),
        .o_report_fail  (report_fail)
    );

    bus_frame_tx u_frame_tx (
        .i_sys_clk     (i_sys_clk),
        .i_sys_resetn  (i_sys_resetn),
        .i_frame_start (frame_start),
        .i_frame_kind  (frame_kind),
        .i_cmd_word    (cmd_word),
        .o_cfg_valid   (o_cfg_valid),
        .o_cfg_msync   (o_cfg_msync),
        .o_cfg_mdata   (o_cfg_mdata),
        .i_cfg_ready   (i_cfg_ready),
        .o_frame_done  (frame_done)
    );

    readback_check #(
        .CHECK_REG (CHECK_REG)
    ) u_check (
        .i_sys_clk    (i_sys_clk),
        .i_sys_resetn (i_sys_resetn),
        .i_clear      (cmd_begin),
        .i_cmd_word   (cmd_word),
        .i_cfg_ssync  (i_cfg_ssync),
        .i_cfg_sdata  (i_cfg_sdata),
        .i_read_done  (read_done),
        .o_mismatch   (mismatch)
    );

    status_reporter u_reporter (
        .i_sys_clk      (i_sys_clk),
        .i_sys_resetn   (i_sys_resetn),
        .i_report_start (report_start),
        .i_report_fail  (report_fail),
        .o_rpt_valid    (o_rpt_valid),
        .i_rpt_ready    (i_rpt_ready),
        .i_rpt_ssync    (i_rpt_ssync),
        .o_rpt_msync    (o_rpt_msync),
        .o_rpt_mdata    (o_rpt_mdata)
    );

endmodule

`default_nettype wire

// File: testbench/tb_sensor_bus_model.sv
`timescale 1ns/100ps
`default_nettype none

module tb_sensor_bus_model (
    input  wire                                i_sys_clk,
    input  wire                                i_valid,
    input  wire                                i_msync,
    input  wire [cam_bus_pkg::BYTE_W-1:0]      i_mdata,
    input  wire                                i_corrupt,      // invert readback of one register
    input  wire [cam_bus_pkg::REG_ADDR_W-1:0]  i_corrupt_reg,
    output logic                               o_ready,
    output logic                               o_ssync,
    output logic [cam_bus_pkg::BYTE_W-1:0]     o_sdata
);

    logic [7:0]  frame [0:7];
    int          nbytes;
    logic [15:0] reg_ptr;         // set by write and address frames
    logic [15:0] regs [0:65535];
    logic [15:0] rd_val;

    initial
    begin
        o_ready <= 1'b0;
        o_ssync <= 1'b0;
        o_sdata <= '0;
        forever
        begin
            @(posedge i_sys_clk);
            if (i_valid)
            begin
                nbytes = 0;
                @(posedge i_sys_clk);
                while (i_msync)  // gather the burst
                begin
                    if (nbytes < 8)
                        frame[nbytes] = i_mdata;
                    nbytes++;
                    @(posedge i_sys_clk);
                end
                if (nbytes >= 3)
                    reg_ptr = {frame[1], frame[2]};
                if (nbytes == 5)
                    regs[reg_ptr] = {frame[3], frame[4]};
                if (nbytes == 1)
                begin
                    rd_val = regs[reg_ptr];
                    if (i_corrupt && reg_ptr == i_corrupt_reg)
                        rd_val = ~rd_val;
                    o_ssync <= 1'b1;
                    o_sdata <= rd_val[15:8];  // high byte first
                    @(posedge i_sys_clk);
                    o_sdata <= rd_val[7:0];
                    @(posedge i_sys_clk);
                    o_ssync <= 1'b0;
                end
                o_ready <= 1'b1;
                @(posedge i_sys_clk);
                o_ready <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_cam_cfg.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cam_cfg;

    localparam int                NUM_CMDS   = 4;
    localparam logic [15:0]       CHECK_REG  = 16'h3012;
    localparam int                MAX_CYCLES = 4000;  // three blocks need about 400
    localparam logic [127:0]      TXT_OK     = "camera config ok";
    localparam logic [127:0]      TXT_ERR    = "camera cfg error";
    localparam logic [31:0]       TXT_TAIL   = {8'h0A, 8'h09, 8'h09, 8'h09};
    localparam logic [NUM_CMDS*32-1:0] CMDS  = {32'h3020_BEEF, 32'h30FF_1234,
                                                32'h3012_0456, 32'h3000_00A5};

    logic                   i_sys_clk;
    logic                   i_sys_resetn;
    logic [NUM_CMDS*32-1:0] i_cmd_array;
    logic                   i_cmd_update;
    wire                    o_cfg_valid;
    wire                    o_cfg_msync;
    wire  [7:0]             o_cfg_mdata;
    wire                    i_cfg_ready;
    wire                    i_cfg_ssync;
    wire  [7:0]             i_cfg_sdata;
    wire                    o_rpt_valid;
    wire                    o_rpt_msync;
    wire  [31:0]            o_rpt_mdata;
    logic                   i_rpt_ready;
    logic                   i_rpt_ssync;

    logic        bad_enable;
    logic [15:0] bad_addr;
    logic        started = 1'b0;
    logic [127:0] exp_msg;
    logic [7:0]  exp_bytes [$];
    int          exp_lens [$];
    int          run_len = 0;
    int          frame_cnt = 0;
    int          rpt_idx = 0;
    int          reports_done = 0;
    int          cycle_cnt = 0;
    int          failures = 0;
    integer      seed = 32'h2188;
    int unsigned gap;

    cam_cfg_top #(
        .NUM_CMDS  (NUM_CMDS),
        .CHECK_REG (CHECK_REG)
    ) DUT (
        .i_sys_clk    (i_sys_clk),
        .i_sys_resetn (i_sys_resetn),
        .i_cmd_array  (i_cmd_array),
        .i_cmd_update (i_cmd_update),
        .o_cfg_valid  (o_cfg_valid),
        .o_cfg_msync  (o_cfg_msync),
        .o_cfg_mdata  (o_cfg_mdata),
        .i_cfg_ready  (i_cfg_ready),
        .i_cfg_ssync  (i_cfg_ssync),
        .i_cfg_sdata  (i_cfg_sdata),
        .o_rpt_valid  (o_rpt_valid),
        .o_rpt_msync  (o_rpt_msync),
        .o_rpt_mdata  (o_rpt_mdata),
        .i_rpt_ready  (i_rpt_ready),
        .i_rpt_ssync  (i_rpt_ssync)
    );

    tb_sensor_bus_model u_sensor (
        .i_sys_clk     (i_sys_clk),
        .i_valid       (o_cfg_valid),
        .i_msync       (o_cfg_msync),
        .i_mdata       (o_cfg_mdata),
        .i_corrupt     (bad_enable),
        .i_corrupt_reg (bad_addr),
        .o_ready       (i_cfg_ready),
        .o_ssync       (i_cfg_ssync),
        .o_sdata       (i_cfg_sdata)
    );

    initial
    begin
        i_sys_clk = 1'b0;
        forever #10 i_sys_clk = ~i_sys_clk;
    end

    // ------------------------------------------------------------
    // failure reporting
    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        failures++;
        $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        abort_run();
    endtask

    task automatic plain_error(input string what);
        failures++;
        $display("%s", what);
        abort_run();
    endtask

    always @(posedge i_sys_clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES)
            plain_error("timeout: the run did not finish within the cycle limit");
    end

    // ------------------------------------------------------------
    // protocol properties
    assert property (@(posedge i_sys_clk) disable iff (!i_sys_resetn)
        !started |-> !(o_cfg_valid || o_cfg_msync || o_rpt_valid || o_rpt_msync))
    else
        plain_error("a channel became active before the first update");

    assert property (@(posedge i_sys_clk) disable iff (!i_sys_resetn)
        o_cfg_valid |=> !o_cfg_valid && o_cfg_msync)
    else
        plain_error("o_cfg_valid was not a single pulse followed by the burst");

    assert property (@(posedge i_sys_clk) disable iff (!i_sys_resetn)
        o_rpt_valid && !i_rpt_ready |=> o_rpt_valid)
    else
        value_error("o_rpt_valid", 32'h0, 32'h1);

    assert property (@(posedge i_sys_clk) disable iff (!i_sys_resetn)
        o_rpt_valid && i_rpt_ready |=> !o_rpt_valid)
    else
        value_error("o_rpt_valid", 32'h1, 32'h0);

    assert property (@(posedge i_sys_clk) disable iff (!i_sys_resetn)
        $rose(o_rpt_msync) |-> $past(i_rpt_ssync))
    else
        plain_error("o_rpt_msync rose without a preceding i_rpt_ssync");

    // command channel bytes and frame lengths
    always @(posedge i_sys_clk)
    begin
        if (i_sys_resetn && o_cfg_msync)
        begin
            if (exp_bytes.size() == 0)
                plain_error("a frame byte arrived with no frame expected");
            assert (o_cfg_mdata == exp_bytes[0])
            else
                value_error("o_cfg_mdata", o_cfg_mdata, exp_bytes[0]);
            void'(exp_bytes.pop_front());
            run_len++;
        end
        else if (i_sys_resetn && run_len != 0)
        begin
            if (exp_lens.size() == 0)
                plain_error("a frame ended with no frame expected");
            assert (run_len == exp_lens[0])
            else
                value_error("o_cfg_msync length", run_len, exp_lens[0]);
            void'(exp_lens.pop_front());
            frame_cnt++;
            run_len = 0;
        end
    end

    // report words
    always @(posedge i_sys_clk)
    begin
        if (i_sys_resetn && o_rpt_msync)
        begin
            if (rpt_idx < cam_report_pkg::RPT_WORDS - 1)
                assert (o_rpt_mdata == exp_msg[127 - 32*rpt_idx -: 32])
                else
                    value_error("o_rpt_mdata", o_rpt_mdata, exp_msg[127 - 32*rpt_idx -: 32]);
            else if (rpt_idx == cam_report_pkg::RPT_WORDS - 1)
                assert (o_rpt_mdata == TXT_TAIL)
                else
                    value_error("o_rpt_mdata", o_rpt_mdata, TXT_TAIL);
            rpt_idx++;
        end
        else if (i_sys_resetn && rpt_idx != 0)
        begin
            assert (rpt_idx == cam_report_pkg::RPT_WORDS)
            else
                value_error("o_rpt_msync length", rpt_idx, cam_report_pkg::RPT_WORDS);
            rpt_idx = 0;
            reports_done++;
        end
    end

    // report receiver with random gaps
    initial
    begin
        i_rpt_ready <= 1'b0;
        i_rpt_ssync <= 1'b0;
        forever
        begin
            @(posedge i_sys_clk);
            if (o_rpt_valid)
            begin
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) @(posedge i_sys_clk);
                i_rpt_ready <= 1'b1;
                @(posedge i_sys_clk);
                i_rpt_ready <= 1'b0;
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) @(posedge i_sys_clk);
                i_rpt_ssync <= 1'b1;
                @(posedge i_sys_clk);
                i_rpt_ssync <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // stimulus
    task automatic queue_command_frames(input logic [31:0] word);
        exp_bytes.push_back(cam_bus_pkg::DEV_WR_ADDR);
        exp_bytes.push_back(word[31:24]);
        exp_bytes.push_back(word[23:16]);
        exp_bytes.push_back(word[15:8]);
        exp_bytes.push_back(word[7:0]);
        exp_lens.push_back(cam_bus_pkg::WR_FRAME_LEN);
        exp_bytes.push_back(cam_bus_pkg::DEV_WR_ADDR);
        exp_bytes.push_back(word[31:24]);
        exp_bytes.push_back(word[23:16]);
        exp_lens.push_back(cam_bus_pkg::ADDR_FRAME_LEN);
        exp_bytes.push_back(cam_bus_pkg::DEV_RD_ADDR);  // two bytes come back
        exp_lens.push_back(cam_bus_pkg::RD_FRAME_LEN);
    endtask

    task automatic run_block(input logic [NUM_CMDS*32-1:0] cmds, input logic bad_en,
                             input logic [15:0] bad_reg, input logic [127:0] msg,
                             input logic extra_update);
        int i;
        int done_before;
        int frames_before;
        done_before   = reports_done;
        frames_before = frame_cnt;
        for (i = 0; i < NUM_CMDS; i++)
            queue_command_frames(cmds[i*32 +: 32]);
        bad_enable   <= bad_en;
        bad_addr     <= bad_reg;
        exp_msg      <= msg;
        i_cmd_array  <= cmds;
        i_cmd_update <= 1'b1;
        started      <= 1'b1;
        @(posedge i_sys_clk);
        i_cmd_update <= 1'b0;
        if (extra_update)
        begin
            while (frame_cnt < frames_before + 4)
                @(posedge i_sys_clk);
            i_cmd_update <= 1'b1;  // ignored while the sequencer is busy
            @(posedge i_sys_clk);
            i_cmd_update <= 1'b0;
        end
        while (reports_done == done_before)
            @(posedge i_sys_clk);
        assert (frame_cnt - frames_before == 3 * NUM_CMDS)
        else
            value_error("frame count", frame_cnt - frames_before, 3 * NUM_CMDS);
    endtask

    initial
    begin
        i_sys_resetn <= 1'b0;
        i_cmd_update <= 1'b0;
        i_cmd_array  <= '0;
        bad_enable   <= 1'b0;
        bad_addr     <= '0;
        exp_msg      <= '0;
        repeat (5) @(posedge i_sys_clk);
        i_sys_resetn <= 1'b1;
        repeat (10) @(posedge i_sys_clk);  // idle window after reset
        run_block(CMDS, 1'b0, 16'h0000, TXT_OK, 1'b1);
        run_block(CMDS, 1'b1, CHECK_REG, TXT_ERR, 1'b0);
        run_block(CMDS, 1'b1, 16'h30FF, TXT_OK, 1'b0);
        repeat (5) @(posedge i_sys_clk);
        if (failures == 0)
        begin
            $display("All checks passed");
            $finish;
        end
        else
            abort_run();
    end

endmodule

`default_nettype wire

// File: verilog.f
source/cam_bus_pkg.sv
source/cam_report_pkg.sv
source/cfg_sequencer.sv
source/bus_frame_tx.sv
source/readback_check.sv
source/status_reporter.sv
source/cam_cfg_top.sv
testbench/tb_sensor_bus_model.sv
testbench/tb_cam_cfg.sv
